// ==== hw/wb_xbar_consts.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone crossbar constants
// Port counts, bus widths and the inclusive target address windows
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef WB_XBAR_CONSTS_SVH
`define WB_XBAR_CONSTS_SVH

// Initiator ports
`define WB_N_INIT 2
// Mapped targets; slot index WB_N_TGT is the decode-fail slot
`define WB_N_TGT 3

// Bus widths
`define WB_ADDR_W 16
`define WB_DATA_W 32

// Address windows, base and limit both inclusive
`define WB_TGT0_BASE 16'h0000
`define WB_TGT0_LIMIT 16'h0FFF
`define WB_TGT1_BASE 16'h1000
`define WB_TGT1_LIMIT 16'h1FFF
`define WB_TGT2_BASE 16'h4000
`define WB_TGT2_LIMIT 16'h40FF

`endif

// ==== hw/wb_bus_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone bus field types
// Address, data and byte-select vectors shared by all crossbar blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "wb_xbar_consts.svh"

package wb_bus_pkg;

	// Byte address as seen on ADR
	typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
	// Read or write data word
	typedef logic [`WB_DATA_W-1:0] wb_data_t;
	// One select bit per data byte
	typedef logic [`WB_DATA_W/8-1:0] wb_sel_t;

endpackage

// ==== hw/xbar_route_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crossbar routing types
// Slot and initiator indices, request vectors and tracker states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "wb_xbar_consts.svh"

package xbar_route_pkg;

	// Mapped slots plus the decode-fail slot
	localparam int SLOT_ID_W = $clog2(`WB_N_TGT + 1);
	// At least one bit, even for a single initiator
	localparam int INIT_ID_W = (`WB_N_INIT > 1) ? $clog2(`WB_N_INIT) : 1;

	typedef logic [SLOT_ID_W-1:0] slot_id_t;
	typedef logic [INIT_ID_W-1:0] init_id_t;
	// Bit i set when initiator i wants the slot
	typedef logic [`WB_N_INIT-1:0] init_req_t;

	typedef enum logic {TRK_IDLE, TRK_WAIT} trk_state_t;

endpackage

// ==== hw/wb_init_decode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Initiator address decoder
// Latches one target slot per initiator request and holds it until the
// routed ACK or ERR
// Builds the request vector of every slot
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "wb_xbar_consts.svh"

module wb_init_decode (
	input  logic                                       clk,
	input  logic                                       rstn,
	input  logic [`WB_N_INIT-1:0]                      cyc_i,
	input  logic [`WB_N_INIT-1:0]                      stb_i,
	input  wb_bus_pkg::wb_addr_t [`WB_N_INIT-1:0]      adr_i,
	input  logic [`WB_N_INIT-1:0]                      resp_done_i,
	output xbar_route_pkg::init_req_t [`WB_N_TGT:0]    slot_req_o,
	output xbar_route_pkg::slot_id_t [`WB_N_INIT-1:0]  trk_slot_o
);

	// One tracker per initiator
	xbar_route_pkg::trk_state_t trk_state [`WB_N_INIT];

	// Inclusive window compare
	function automatic logic in_window(input wb_bus_pkg::wb_addr_t adr,
			input wb_bus_pkg::wb_addr_t base, input wb_bus_pkg::wb_addr_t limit);
		return (adr >= base) && (adr <= limit);
	endfunction

	// Map an address to its slot or to the decode-fail slot on a miss
	function automatic xbar_route_pkg::slot_id_t addr_to_slot(input wb_bus_pkg::wb_addr_t adr);
		xbar_route_pkg::slot_id_t res;
		if (in_window(adr, `WB_TGT0_BASE, `WB_TGT0_LIMIT)) begin
			res = xbar_route_pkg::slot_id_t'(0);
		end else if (in_window(adr, `WB_TGT1_BASE, `WB_TGT1_LIMIT)) begin
			res = xbar_route_pkg::slot_id_t'(1);
		end else if (in_window(adr, `WB_TGT2_BASE, `WB_TGT2_LIMIT)) begin
			res = xbar_route_pkg::slot_id_t'(2);
		end else begin
			res = xbar_route_pkg::slot_id_t'(`WB_N_TGT);
		end
		return res;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < `WB_N_INIT; i++) begin
				trk_state[i] <= xbar_route_pkg::TRK_IDLE;
				trk_slot_o[i] <= xbar_route_pkg::slot_id_t'(`WB_N_TGT);
			end
		end else begin
			for (int i = 0; i < `WB_N_INIT; i++) begin
				case (trk_state[i])
					xbar_route_pkg::TRK_IDLE: begin
						// Decode once on the first cycle of the strobe
						if (cyc_i[i] && stb_i[i]) begin
							trk_slot_o[i] <= addr_to_slot(adr_i[i]);
							trk_state[i] <= xbar_route_pkg::TRK_WAIT;
						end
					end
					xbar_route_pkg::TRK_WAIT: begin
						// Routed ACK or ERR ends the transfer
						if (resp_done_i[i]) begin
							trk_state[i] <= xbar_route_pkg::TRK_IDLE;
						end
					end
					default: trk_state[i] <= xbar_route_pkg::TRK_IDLE;
				endcase
			end
		end
	end

	// Request bits only while a tracker waits on that slot
	always_comb begin
		for (int s = 0; s <= `WB_N_TGT; s++) begin
			for (int i = 0; i < `WB_N_INIT; i++) begin
				slot_req_o[s][i] = (trk_state[i] == xbar_route_pkg::TRK_WAIT) &&
					(trk_slot_o[i] == xbar_route_pkg::slot_id_t'(s));
			end
		end
	end

	// A waiting tracker's slot still matches the address the initiator holds
	for (genvar g = 0; g < `WB_N_INIT; g++) begin : g_trk_chk
		a_slot_hold: assert property (@(posedge clk) disable iff (!rstn)
			trk_state[g] == xbar_route_pkg::TRK_WAIT && cyc_i[g] && stb_i[g] |->
				trk_slot_o[g] == addr_to_slot(adr_i[g]));
	end

endmodule

// ==== hw/wb_slot_arbiter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Target slot arbiter
// Round-robin choice between initiators that holds the grant while the
// winner keeps requesting and forwards the winner's request fields
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "wb_xbar_consts.svh"

module wb_slot_arbiter (
	input  logic                                   clk,
	input  logic                                   rstn,
	input  xbar_route_pkg::init_req_t              req_i,
	input  logic [`WB_N_INIT-1:0]                  init_cyc_i,
	input  logic [`WB_N_INIT-1:0]                  init_stb_i,
	input  logic [`WB_N_INIT-1:0]                  init_we_i,
	input  wb_bus_pkg::wb_addr_t [`WB_N_INIT-1:0]  init_adr_i,
	input  wb_bus_pkg::wb_sel_t [`WB_N_INIT-1:0]   init_sel_i,
	input  wb_bus_pkg::wb_data_t [`WB_N_INIT-1:0]  init_dat_i,
	output logic                                   gnt_o,
	output xbar_route_pkg::init_id_t               gnt_id_o,
	output logic                                   cyc_o,
	output logic                                   stb_o,
	output logic                                   we_o,
	output wb_bus_pkg::wb_addr_t                   adr_o,
	output wb_bus_pkg::wb_sel_t                    sel_o,
	output wb_bus_pkg::wb_data_t                   dat_o
);

	logic                     gnt_q;
	// Current winner that stays as the last grant after release
	xbar_route_pkg::init_id_t gnt_id_q;
	logic                     pick_vld;
	xbar_route_pkg::init_id_t pick_id;
	logic                     fwd;

	// Next winner
	always_comb begin
		pick_vld = 1'b0;
		pick_id = '0;
		// Fallback is the lowest requesting index
		for (int k = `WB_N_INIT - 1; k >= 0; k--) begin
			if (req_i[k]) begin
				pick_vld = 1'b1;
				pick_id = xbar_route_pkg::init_id_t'(k);
			end
		end
		// First requester above the last grant wins if there is one
		for (int k = `WB_N_INIT - 1; k >= 0; k--) begin
			if (req_i[k] && k > int'(gnt_id_q)) begin
				pick_id = xbar_route_pkg::init_id_t'(k);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q <= 1'b0;
			gnt_id_q <= '0;
		end else if (!gnt_q) begin
			if (pick_vld) begin
				gnt_q <= 1'b1;
				gnt_id_q <= pick_id;
			end
		end else if (!req_i[gnt_id_q]) begin
			// Winner's tracker went idle so the slot is freed
			gnt_q <= 1'b0;
		end
	end

	assign gnt_o = gnt_q;
	assign gnt_id_o = gnt_id_q;

	// Forward only while the winner still tracks this slot so that a
	// follow-on request never leaks into the old target
	assign fwd = gnt_q && req_i[gnt_id_q];

	assign cyc_o = fwd && init_cyc_i[gnt_id_q];
	assign stb_o = fwd && init_stb_i[gnt_id_q];
	assign we_o = fwd && init_we_i[gnt_id_q];
	assign adr_o = fwd ? init_adr_i[gnt_id_q] : '0;
	assign sel_o = fwd ? init_sel_i[gnt_id_q] : '0;
	assign dat_o = fwd ? init_dat_i[gnt_id_q] : '0;

	// A free slot passes to another waiting initiator before the last winner
	a_rr_turn: assert property (@(posedge clk) disable iff (!rstn)
		!gnt_q && (req_i & ~(xbar_route_pkg::init_req_t'(1) << gnt_id_q)) != '0 |=>
			gnt_q && gnt_id_q != $past(gnt_id_q));

	// Initiators keep CYC up around every strobe
	a_stb_cyc: assert property (@(posedge clk) disable iff (!rstn)
		stb_o |-> cyc_o);

endmodule

// ==== hw/wb_resp_route.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crossbar response router
// Returns ACK, ERR and read data to the initiator holding each slot;
// also holds the decode-fail responder behind the last slot
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "wb_xbar_consts.svh"

module wb_resp_route (
	input  logic                                       clk,
	input  logic                                       rstn,
	input  xbar_route_pkg::slot_id_t [`WB_N_INIT-1:0]  trk_slot_i,
	input  logic [`WB_N_TGT:0]                         gnt_i,
	input  xbar_route_pkg::init_id_t [`WB_N_TGT:0]     gnt_id_i,
	input  logic [`WB_N_TGT-1:0]                       tgt_ack_i,
	input  logic [`WB_N_TGT-1:0]                       tgt_err_i,
	input  wb_bus_pkg::wb_data_t [`WB_N_TGT-1:0]       tgt_dat_i,
	input  logic                                       err_stb_i,
	input  logic                                       err_cyc_i,
	output logic [`WB_N_INIT-1:0]                      init_ack_o,
	output logic [`WB_N_INIT-1:0]                      init_err_o,
	output wb_bus_pkg::wb_data_t [`WB_N_INIT-1:0]      init_dat_o,
	output logic [`WB_N_INIT-1:0]                      resp_done_o
);

	// Decode-fail responder, one ERR pulse per strobe
	logic                                  err_q;
	// Responses of all slots, decode-fail slot on top
	logic [`WB_N_TGT:0]                    slot_ack;
	logic [`WB_N_TGT:0]                    slot_err;
	wb_bus_pkg::wb_data_t [`WB_N_TGT:0]    slot_dat;

	// ERR the cycle after STB; the pulse blocks a second one for the same strobe
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= err_cyc_i && err_stb_i && !err_q;
		end
	end

	assign slot_ack = {1'b0, tgt_ack_i};
	assign slot_err = {err_q, tgt_err_i};
	// Missed reads return zero
	assign slot_dat = {wb_bus_pkg::wb_data_t'(0), tgt_dat_i};

	// Pass a slot's response only when it is tracked and granted to this initiator
	always_comb begin
		init_ack_o = '0;
		init_err_o = '0;
		init_dat_o = '0;
		for (int i = 0; i < `WB_N_INIT; i++) begin
			for (int s = 0; s <= `WB_N_TGT; s++) begin
				if (trk_slot_i[i] == xbar_route_pkg::slot_id_t'(s) && gnt_i[s] &&
						gnt_id_i[s] == xbar_route_pkg::init_id_t'(i)) begin
					init_ack_o[i] = slot_ack[s];
					init_err_o[i] = slot_err[s];
					init_dat_o[i] = slot_dat[s];
				end
			end
		end
	end

	// Tracker release strobe
	assign resp_done_o = init_ack_o | init_err_o;

	// Targets and responder must never terminate one strobe both ways
	a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstn)
		(init_ack_o & init_err_o) == '0);

endmodule

// ==== hw/wb_xbar_2x3.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic crossbar, two initiators to three targets
// Unmapped addresses end in ERR from an internal fourth slot
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "wb_xbar_consts.svh"

module wb_xbar_2x3 (
	input  logic                                   clk,
	input  logic                                   rstn,
	// Initiator side
	input  logic [`WB_N_INIT-1:0]                  init_cyc_i,
	input  logic [`WB_N_INIT-1:0]                  init_stb_i,
	input  logic [`WB_N_INIT-1:0]                  init_we_i,
	input  wb_bus_pkg::wb_addr_t [`WB_N_INIT-1:0]  init_adr_i,
	input  wb_bus_pkg::wb_sel_t [`WB_N_INIT-1:0]   init_sel_i,
	input  wb_bus_pkg::wb_data_t [`WB_N_INIT-1:0]  init_dat_i,
	output logic [`WB_N_INIT-1:0]                  init_ack_o,
	output logic [`WB_N_INIT-1:0]                  init_err_o,
	output wb_bus_pkg::wb_data_t [`WB_N_INIT-1:0]  init_dat_o,
	// Target side
	output logic [`WB_N_TGT-1:0]                   tgt_cyc_o,
	output logic [`WB_N_TGT-1:0]                   tgt_stb_o,
	output logic [`WB_N_TGT-1:0]                   tgt_we_o,
	output wb_bus_pkg::wb_addr_t [`WB_N_TGT-1:0]   tgt_adr_o,
	output wb_bus_pkg::wb_sel_t [`WB_N_TGT-1:0]    tgt_sel_o,
	output wb_bus_pkg::wb_data_t [`WB_N_TGT-1:0]   tgt_dat_o,
	input  logic [`WB_N_TGT-1:0]                   tgt_ack_i,
	input  logic [`WB_N_TGT-1:0]                   tgt_err_i,
	input  wb_bus_pkg::wb_data_t [`WB_N_TGT-1:0]   tgt_dat_i
);

	xbar_route_pkg::init_req_t [`WB_N_TGT:0]    slot_req;
	xbar_route_pkg::slot_id_t [`WB_N_INIT-1:0]  trk_slot;
	logic [`WB_N_INIT-1:0]                      resp_done;
	logic [`WB_N_TGT:0]                         slot_gnt;
	xbar_route_pkg::init_id_t [`WB_N_TGT:0]     slot_gnt_id;
	// Forwarded fields of every slot, top entry feeds the ERR responder
	logic [`WB_N_TGT:0]                         slot_cyc;
	logic [`WB_N_TGT:0]                         slot_stb;
	logic [`WB_N_TGT:0]                         slot_we;
	wb_bus_pkg::wb_addr_t [`WB_N_TGT:0]         slot_adr;
	wb_bus_pkg::wb_sel_t [`WB_N_TGT:0]          slot_sel;
	wb_bus_pkg::wb_data_t [`WB_N_TGT:0]         slot_dat;

	wb_init_decode u_decode (
		.clk(clk), .rstn(rstn),
		.cyc_i(init_cyc_i), .stb_i(init_stb_i), .adr_i(init_adr_i),
		.resp_done_i(resp_done),
		.slot_req_o(slot_req), .trk_slot_o(trk_slot)
	);

	// One arbiter per slot, decode-fail slot included
	for (genvar s = 0; s <= `WB_N_TGT; s++) begin : g_slot
		wb_slot_arbiter u_arb (
			.clk(clk), .rstn(rstn), .req_i(slot_req[s]),
			.init_cyc_i(init_cyc_i), .init_stb_i(init_stb_i), .init_we_i(init_we_i),
			.init_adr_i(init_adr_i), .init_sel_i(init_sel_i), .init_dat_i(init_dat_i),
			.gnt_o(slot_gnt[s]), .gnt_id_o(slot_gnt_id[s]),
			.cyc_o(slot_cyc[s]), .stb_o(slot_stb[s]), .we_o(slot_we[s]),
			.adr_o(slot_adr[s]), .sel_o(slot_sel[s]), .dat_o(slot_dat[s])
		);
	end

	// Mapped slots go out to the targets
	assign tgt_cyc_o = slot_cyc[`WB_N_TGT-1:0];
	assign tgt_stb_o = slot_stb[`WB_N_TGT-1:0];
	assign tgt_we_o = slot_we[`WB_N_TGT-1:0];
	assign tgt_adr_o = slot_adr[`WB_N_TGT-1:0];
	assign tgt_sel_o = slot_sel[`WB_N_TGT-1:0];
	assign tgt_dat_o = slot_dat[`WB_N_TGT-1:0];

	wb_resp_route u_route (
		.clk(clk), .rstn(rstn),
		.trk_slot_i(trk_slot), .gnt_i(slot_gnt), .gnt_id_i(slot_gnt_id),
		.tgt_ack_i(tgt_ack_i), .tgt_err_i(tgt_err_i), .tgt_dat_i(tgt_dat_i),
		.err_stb_i(slot_stb[`WB_N_TGT]), .err_cyc_i(slot_cyc[`WB_N_TGT]),
		.init_ack_o(init_ack_o), .init_err_o(init_err_o), .init_dat_o(init_dat_o),
		.resp_done_o(resp_done)
	);

endmodule

// ==== tests/tb_clk_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset, 40 ns period, reset low for 5 cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk_o,
	output logic rstn_o
);

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;
	end

	// Released just after the fifth rising edge, like any other input
	initial begin
		rstn_o = 1'b0;
		repeat (5) @(posedge clk_o);
		#2 rstn_o = 1'b1;
	end

endmodule

// ==== tests/tb_wb_target.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral Wishbone memory target, 256 words
// ACK after a random wait of 0 to 3 extra cycles, one ACK per strobe
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "wb_xbar_consts.svh"

module tb_wb_target #(
	parameter wb_bus_pkg::wb_addr_t BASE = '0
) (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  wb_bus_pkg::wb_addr_t adr_i,
	input  wb_bus_pkg::wb_sel_t  sel_i,
	input  wb_bus_pkg::wb_data_t dat_i,
	output logic                 ack_o,
	output wb_bus_pkg::wb_data_t dat_o
);

	wb_bus_pkg::wb_data_t mem [256];
	// Known values before the first clock edge
	logic                 ack_q = 1'b0;
	wb_bus_pkg::wb_data_t rdat_q = '0;
	logic                 busy;
	logic [1:0]           wait_cnt;
	logic [7:0]           idx;

	// Word index inside the window
	assign idx = adr_i[9:2];
	assign ack_o = ack_q;
	assign dat_o = rdat_q;

	always @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
			rdat_q <= '0;
			busy <= 1'b0;
			wait_cnt <= '0;
			// Fill, byte address of the word in the low half, its inverse on top
			for (int i = 0; i < 256; i++) begin
				mem[i] <= {~(BASE + 16'(i * 4)), BASE + 16'(i * 4)};
			end
		end else begin
			ack_q <= 1'b0;
			if (ack_q) begin
				// Strobe still up for one cycle after ACK, it belongs to the finished transfer
				busy <= 1'b0;
			end else if (cyc_i && stb_i) begin
				if (!busy) begin
					busy <= 1'b1;
					wait_cnt <= 2'($urandom_range(3, 0));
				end else if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					ack_q <= 1'b1;
					busy <= 1'b0;
					if (we_i) begin
						for (int b = 0; b < `WB_DATA_W / 8; b++) begin
							if (sel_i[b]) begin
								mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
							end
						end
					end else begin
						rdat_q <= mem[idx];
					end
				end
			end else begin
				busy <= 1'b0;
			end
		end
	end

endmodule

// ==== tests/tb_wb_xbar.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone crossbar testbench
// Random reads and writes from two initiators, checked against shadow
// memories, the address map and the round-robin fairness rule
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "wb_xbar_consts.svh"

module tb_wb_xbar;

	localparam logic [31:0] SEED = 32'h591d_57ea;
	// Run limit, transactions per initiator times cycles per transaction
	localparam int TXN_MAX = 200;
	localparam int CYC_PER_TXN = 12;
	localparam int CYCLE_LIMIT = TXN_MAX * CYC_PER_TXN;
	localparam wb_bus_pkg::wb_addr_t WIN_BASE [`WB_N_TGT] =
		'{`WB_TGT0_BASE, `WB_TGT1_BASE, `WB_TGT2_BASE};
	localparam wb_bus_pkg::wb_addr_t WIN_LIM [`WB_N_TGT] =
		'{`WB_TGT0_LIMIT, `WB_TGT1_LIMIT, `WB_TGT2_LIMIT};

	logic                                  clk;
	logic                                  rstn;
	logic [`WB_N_INIT-1:0]                 init_cyc;
	logic [`WB_N_INIT-1:0]                 init_stb;
	logic [`WB_N_INIT-1:0]                 init_we;
	wb_bus_pkg::wb_addr_t [`WB_N_INIT-1:0] init_adr;
	wb_bus_pkg::wb_sel_t [`WB_N_INIT-1:0]  init_sel;
	wb_bus_pkg::wb_data_t [`WB_N_INIT-1:0] init_wdat;
	logic [`WB_N_INIT-1:0]                 init_ack;
	logic [`WB_N_INIT-1:0]                 init_err;
	wb_bus_pkg::wb_data_t [`WB_N_INIT-1:0] init_rdat;
	logic [`WB_N_TGT-1:0]                  tgt_cyc;
	logic [`WB_N_TGT-1:0]                  tgt_stb;
	logic [`WB_N_TGT-1:0]                  tgt_we;
	wb_bus_pkg::wb_addr_t [`WB_N_TGT-1:0]  tgt_adr;
	wb_bus_pkg::wb_sel_t [`WB_N_TGT-1:0]   tgt_sel;
	wb_bus_pkg::wb_data_t [`WB_N_TGT-1:0]  tgt_wdat;
	logic [`WB_N_TGT-1:0]                  tgt_ack;
	logic [`WB_N_TGT-1:0]                  tgt_err;
	wb_bus_pkg::wb_data_t [`WB_N_TGT-1:0]  tgt_rdat;

	// Shadow copy of every target memory
	wb_bus_pkg::wb_data_t shadow [`WB_N_TGT][256];
	// Completed transactions per initiator
	int done_cnt [`WB_N_INIT];
	int cycles = 0;

	tb_clk_gen i_clk_gen (.clk_o(clk), .rstn_o(rstn));

	wb_xbar_2x3 i_dut (
		.clk(clk), .rstn(rstn),
		.init_cyc_i(init_cyc), .init_stb_i(init_stb), .init_we_i(init_we),
		.init_adr_i(init_adr), .init_sel_i(init_sel), .init_dat_i(init_wdat),
		.init_ack_o(init_ack), .init_err_o(init_err), .init_dat_o(init_rdat),
		.tgt_cyc_o(tgt_cyc), .tgt_stb_o(tgt_stb), .tgt_we_o(tgt_we),
		.tgt_adr_o(tgt_adr), .tgt_sel_o(tgt_sel), .tgt_dat_o(tgt_wdat),
		.tgt_ack_i(tgt_ack), .tgt_err_i(tgt_err), .tgt_dat_i(tgt_rdat)
	);

	// Memories never answer with ERR
	assign tgt_err = '0;

	for (genvar g = 0; g < `WB_N_TGT; g++) begin : g_tgt
		tb_wb_target #(.BASE(WIN_BASE[g])) i_tgt (
			.clk(clk), .rstn(rstn),
			.cyc_i(tgt_cyc[g]), .stb_i(tgt_stb[g]), .we_i(tgt_we[g]),
			.adr_i(tgt_adr[g]), .sel_i(tgt_sel[g]), .dat_i(tgt_wdat[g]),
			.ack_o(tgt_ack[g]), .dat_o(tgt_rdat[g])
		);
	end

	task automatic check_val(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "Value mismatch in %s", name);
		end
	endtask

	// Random word address in window t, t == WB_N_TGT gives unmapped space
	function automatic wb_bus_pkg::wb_addr_t rand_addr(input int t);
		logic [31:0] r;
		r = $urandom;
		if (t < `WB_N_TGT) begin
			return WIN_BASE[t] + (r[15:0] & (WIN_LIM[t] - WIN_BASE[t]) & 16'hFFFC);
		end
		// Holes at 0x2000-0x3FFF and 0x8000-0xFFFF
		return r[16] ? (16'h2000 | (r[15:0] & 16'h1FFC)) : (16'h8000 | (r[15:0] & 16'h7FFC));
	endfunction

	// One classic cycle, entered and left 2 ns after a rising edge
	task automatic do_txn(input int ini, input int t, input wb_bus_pkg::wb_addr_t adr,
			input logic we, input bit fair);
		wb_bus_pkg::wb_data_t wdat;
		wb_bus_pkg::wb_sel_t  sel;
		int                   other_start;
		wdat = $urandom;
		sel = wb_bus_pkg::wb_sel_t'($urandom_range(15, 1));
		other_start = done_cnt[1 - ini];
		init_cyc[ini] = 1'b1;
		init_stb[ini] = 1'b1;
		init_we[ini] = we;
		init_adr[ini] = adr;
		init_sel[ini] = sel;
		init_wdat[ini] = we ? wdat : '0;
		// Nothing left over from the previous transfer
		@(negedge clk);
		check_val("stale response", 32'd0, 32'({init_ack[ini], init_err[ini]}));
		while (!(init_ack[ini] || init_err[ini])) begin
			@(negedge clk);
		end
		if (t == `WB_N_TGT) begin
			check_val("miss ERR", 32'd1, 32'(init_err[ini]));
			check_val("miss ACK", 32'd0, 32'(init_ack[ini]));
		end else begin
			check_val("ACK", 32'd1, 32'(init_ack[ini]));
			check_val("ERR", 32'd0, 32'(init_err[ini]));
			if (we) begin
				for (int b = 0; b < `WB_DATA_W / 8; b++) begin
					if (sel[b]) begin
						shadow[t][adr[9:2]][8*b +: 8] = wdat[8*b +: 8];
					end
				end
			end else begin
				check_val("read data", shadow[t][adr[9:2]], init_rdat[ini]);
			end
		end
		done_cnt[ini]++;
		// Round robin lets the other initiator finish at most once meanwhile
		if (fair) begin
			check_val("contention wait", 32'd1, 32'(done_cnt[1 - ini] - other_start <= 1));
		end
		@(posedge clk);
		#2;
		init_cyc[ini] = 1'b0;
		init_stb[ini] = 1'b0;
	endtask

	// n random transfers to slot tgt, or to any slot when tgt is negative
	task automatic run_random(input int ini, input int tgt, input int n, input bit fair);
		int t;
		for (int k = 0; k < n; k++) begin
			t = (tgt < 0) ? int'($urandom_range(`WB_N_TGT, 0)) : tgt;
			do_txn(ini, t, rand_addr(t), 1'($urandom_range(1, 0)), fair);
		end
	endtask

	// Each target only ever sees addresses of its own window
	always @(negedge clk) begin
		if (rstn) begin
			for (int t = 0; t < `WB_N_TGT; t++) begin
				if (tgt_stb[t]) begin
					check_val("target window", 32'd1,
						32'(tgt_adr[t] >= WIN_BASE[t] && tgt_adr[t] <= WIN_LIM[t]));
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("SIMULATION FAILED");
			$fatal(1, "Timeout, transfers still running after %0d cycles", CYCLE_LIMIT);
		end
	end

	initial begin
		wb_bus_pkg::wb_addr_t adr;
		void'($urandom(SEED));
		init_cyc = '0;
		init_stb = '0;
		init_we = '0;
		init_adr = '0;
		init_sel = '0;
		init_wdat = '0;
		for (int i = 0; i < `WB_N_INIT; i++) begin
			done_cnt[i] = 0;
		end
		// Same fill as the targets
		for (int t = 0; t < `WB_N_TGT; t++) begin
			for (int i = 0; i < 256; i++) begin
				shadow[t][i] = {~(WIN_BASE[t] + 16'(i * 4)), WIN_BASE[t] + 16'(i * 4)};
			end
		end
		// Bus quiet during reset and on the first cycle after it
		do begin
			@(negedge clk);
			check_val("reset tgt_cyc", 32'd0, 32'(tgt_cyc));
			check_val("reset tgt_stb", 32'd0, 32'(tgt_stb));
			check_val("reset init_ack", 32'd0, 32'(init_ack));
			check_val("reset init_err", 32'd0, 32'(init_err));
		end while (rstn !== 1'b1);
		@(posedge clk);
		#2;
		// Write then read back, initiator 0 alone, every target
		for (int t = 0; t < `WB_N_TGT; t++) begin
			for (int n = 0; n < 8; n++) begin
				adr = rand_addr(t);
				do_txn(0, t, adr, 1'b1, 1'b0);
				do_txn(0, t, adr, 1'b0, 1'b0);
			end
		end
		// Unmapped addresses
		run_random(1, `WB_N_TGT, 8, 1'b0);
		// Both on target 1
		fork
			run_random(0, 1, 40, 1'b1);
			run_random(1, 1, 40, 1'b1);
		join
		run_random(0, 1, 8, 1'b0);
		// Disjoint targets side by side
		fork
			run_random(0, 0, 40, 1'b0);
			run_random(1, 2, 40, 1'b0);
		join
		// Mixed traffic, misses included
		fork
			run_random(0, -1, 40, 1'b0);
			run_random(1, -1, 40, 1'b0);
		join
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== wb_xbar.f ====
+incdir+hw
hw/wb_bus_pkg.sv
hw/xbar_route_pkg.sv
hw/wb_init_decode.sv
hw/wb_slot_arbiter.sv
hw/wb_resp_route.sv
hw/wb_xbar_2x3.sv
tests/tb_clk_gen.sv
tests/tb_wb_target.sv
tests/tb_wb_xbar.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_wb_xbar
FILELIST := wb_xbar.f
OBJDIR   := obj_dir
FLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJDIR)
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
